//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := circle_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
logic/screen_pkg.sv
logic/circle_pkg.sv
logic/pixel_if.sv
logic/circle_fsm.sv
logic/octant_counter.sv
logic/plot_generator.sv
logic/frame_buffer.sv
logic/circle_top.sv
sim/circle_tb.sv

//--- logic/circle_fsm.sv
/*
 * circle_fsm
 *   top level sequencer: idle, clearing, drawing, finished
 *   issues clear_go and draw_go pulses and raises done at the end
 */

`default_nettype none
`timescale 1ns/100ps

module circle_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic phase_end,  // last pixel of the current phase has gone out
    output logic clear_go,
    output logic draw_go,
    output logic done
);

    enum logic [1:0] {idle, clearing, drawing, finished} state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            clear_go <= 1'b0;
            draw_go  <= 1'b0;
        end else begin
            clear_go <= 1'b0;  // both go signals are single cycle pulses
            draw_go  <= 1'b0;

            case (state)
                idle, finished: begin
                    // a new start is only taken when nothing is running
                    if (start) begin
                        state    <= clearing;
                        clear_go <= 1'b1;
                    end
                end

                clearing: begin
                    if (phase_end) begin
                        state   <= drawing;
                        draw_go <= 1'b1;  // screen is black, begin the outline
                    end
                end

                drawing: begin
                    if (phase_end)
                        state <= finished;
                end

                default: state <= idle;
            endcase
        end
    end

    // done holds until the next accepted start
    assign done = (state == finished);

    // the two phases are never kicked off in the same cycle
    a_go_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(clear_go && draw_go)
    );

endmodule : circle_fsm

`default_nettype wire

//--- logic/circle_pkg.sv
/*
 * circle_pkg
 *   widths used by the midpoint circle algorithm
 *   and the number of octants drawn per offset pair
 */

`default_nettype none

package circle_pkg;

    localparam int radius_w = 8;  // radius 0..255

    // signed offsets have to hold the full radius plus a sign bit
    localparam int offset_w = 9;

    // decision term, wide enough for 2*(y-x)+1 at the largest radius
    localparam int crit_w = 11;

    // eight mirrored pixels for every offset pair
    localparam int octant_w = 3;
    localparam int octants = 8;

endpackage : circle_pkg

`default_nettype wire

//--- logic/circle_top.sv
/*
 * circle_top
 *   circle drawing block: sequencer, midpoint stepper, pixel path
 *   and frame buffer, exposing a plain valid/ready plot stream
 */

`default_nettype none
`timescale 1ns/100ps

module circle_top import screen_pkg::*, circle_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [x_w-1:0]      centre_x,
    input  logic [y_w-1:0]      centre_y,
    input  logic [radius_w-1:0] radius,
    input  logic [colour_w-1:0] colour,
    input  logic                plot_ready,  // from the outside display
    input  logic [x_w-1:0]      rd_x,
    input  logic [y_w-1:0]      rd_y,
    output logic                done,
    output logic [x_w-1:0]      vga_x,
    output logic [y_w-1:0]      vga_y,
    output logic [colour_w-1:0] vga_colour,
    output logic                vga_plot,
    output logic [colour_w-1:0] rd_colour
);

    logic clear_go, draw_go, phase_end, step, last;

    logic [offset_w-1:0] offset_x, offset_y;
    logic [octant_w-1:0] octant;

    pixel_if pix ();

    circle_fsm fsm (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .phase_end (phase_end),
        .clear_go  (clear_go),
        .draw_go   (draw_go),
        .done      (done)
    );

    // the stepper restarts from the radius when drawing is kicked off
    octant_counter counter (
        .clk      (clk),
        .reset    (reset),
        .load     (draw_go),
        .radius   (radius),
        .step     (step),
        .offset_x (offset_x),
        .offset_y (offset_y),
        .octant   (octant),
        .last     (last)
    );

    plot_generator plotter (
        .clk       (clk),
        .reset     (reset),
        .clear_go  (clear_go),
        .draw_go   (draw_go),
        .centre_x  (centre_x),
        .centre_y  (centre_y),
        .colour    (colour),
        .offset_x  (offset_x),
        .offset_y  (offset_y),
        .octant    (octant),
        .last      (last),
        .step      (step),
        .phase_end (phase_end),
        .pix       (pix)
    );

    frame_buffer fbuf (
        .clk       (clk),
        .pix       (pix),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_colour (rd_colour)
    );

    assign pix.ready = plot_ready;

    // the plot stream leaves exactly as the frame buffer sees it
    assign vga_x      = pix.x;
    assign vga_y      = pix.y;
    assign vga_colour = pix.colour;
    assign vga_plot   = pix.valid;

endmodule : circle_top

`default_nettype wire

//--- logic/frame_buffer.sv
/*
 * frame_buffer
 *   160x120 colour memory mirroring every accepted pixel,
 *   with a read port whose output is registered
 */

`default_nettype none
`timescale 1ns/100ps

module frame_buffer import screen_pkg::*; (
    input  logic                clk,
    pixel_if.sink               pix,
    input  logic [x_w-1:0]      rd_x,
    input  logic [y_w-1:0]      rd_y,
    output logic [colour_w-1:0] rd_colour
);

    logic [colour_w-1:0] mem [screen_w * screen_h];

    logic [addr_w-1:0] wr_addr, rd_addr;

    // row major, one row is screen_w words
    assign wr_addr = addr_w'(pix.y) * addr_w'(screen_w) + addr_w'(pix.x);
    assign rd_addr = addr_w'(rd_y) * addr_w'(screen_w) + addr_w'(rd_x);

    always_ff @(posedge clk) begin
        if (pix.valid && pix.ready)
            mem[wr_addr] <= pix.colour;  // only transferred pixels are stored
        rd_colour <= mem[rd_addr];       // result one cycle after the address
    end

    // clipping upstream keeps every presented pixel inside the memory
    a_on_screen: assert property (
        @(posedge clk)
        pix.valid |-> (pix.x < x_w'(screen_w)) && (pix.y < y_w'(screen_h))
    );

endmodule : frame_buffer

`default_nettype wire

//--- logic/octant_counter.sv
/*
 * octant_counter
 *   midpoint circle stepper: x/y offsets, decision term and
 *   octant index, with a flag for the very last octant pixel
 */

`default_nettype none
`timescale 1ns/100ps

module octant_counter import circle_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,      // start a new circle
    input  logic [radius_w-1:0] radius,
    input  logic                step,      // current octant pixel is dealt with
    output logic [offset_w-1:0] offset_x,
    output logic [offset_w-1:0] offset_y,
    output logic [octant_w-1:0] octant,
    output logic                last
);

    logic signed [offset_w-1:0] ox, oy;
    logic signed [crit_w-1:0]   crit;
    logic [octant_w-1:0]        oct;

    // midpoint update for the next offset pair
    logic signed [offset_w-1:0] ox_nxt, oy_nxt;
    logic signed [crit_w-1:0]   crit_nxt;
    logic signed [crit_w-1:0]   ox_wide, oy_wide;
    logic                       final_oct;

    assign final_oct = (oct == octant_w'(octants - 1));

    always_comb begin
        oy_nxt = oy + 1'b1;
        if (crit <= 0)
            ox_nxt = ox;          // stay on the same column
        else
            ox_nxt = ox - 1'b1;   // move one step inwards
        ox_wide = ox_nxt;         // sign extended to the decision width
        oy_wide = oy_nxt;
        if (crit <= 0)
            crit_nxt = crit + 2 * oy_wide + 1;
        else
            crit_nxt = crit + 2 * (oy_wide - ox_wide) + 1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ox   <= '0;
            oy   <= '0;
            crit <= '0;
            oct  <= '0;
        end else if (load) begin
            ox   <= {{(offset_w - radius_w){1'b0}}, radius};
            oy   <= '0;
            crit <= crit_w'(1) - crit_w'(radius);
            oct  <= '0;
        end else if (step) begin
            if (final_oct) begin
                oct  <= '0;  // all eight mirrors done, advance the pair
                ox   <= ox_nxt;
                oy   <= oy_nxt;
                crit <= crit_nxt;
            end else begin
                oct <= oct + 1'b1;
            end
        end
    end

    assign offset_x = ox;
    assign offset_y = oy;
    assign octant   = oct;

    // no further pair once y would pass x
    assign last = final_oct && (oy_nxt > ox_nxt);

    a_octant_hold: assert property (
        @(posedge clk) disable iff (reset)
        (!load && !step) |=> $stable(oct)
    );

endmodule : octant_counter

`default_nettype wire

//--- logic/pixel_if.sv
/*
 * pixel_if
 *   one pixel write (x, y, colour) with a valid/ready handshake
 *   source modport for the pixel producer, sink for observers
 */

`default_nettype none
`timescale 1ns/100ps

interface pixel_if import screen_pkg::*; ();

    logic [x_w-1:0]      x;
    logic [y_w-1:0]      y;
    logic [colour_w-1:0] colour;
    logic                valid;  // pixel is presented
    logic                ready;  // display accepts it this cycle

    // the producer holds x, y and colour steady until the transfer
    modport source (
        output x, y, colour, valid,
        input  ready
    );

    // a sink only watches; ready comes from the outside display
    modport sink (
        input x, y, colour, valid, ready
    );

endinterface : pixel_if

`default_nettype wire

//--- logic/plot_generator.sv
/*
 * plot_generator
 *   turns the full-screen clear scan or the current octant offsets
 *   into pixel writes, skips pixels that fall off the screen
 *   and reports the end of each phase
 */

`default_nettype none
`timescale 1ns/100ps

module plot_generator import screen_pkg::*, circle_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear_go,
    input  logic                draw_go,
    input  logic [x_w-1:0]      centre_x,
    input  logic [y_w-1:0]      centre_y,
    input  logic [colour_w-1:0] colour,
    input  logic [offset_w-1:0] offset_x,
    input  logic [offset_w-1:0] offset_y,
    input  logic [octant_w-1:0] octant,
    input  logic                last,
    output logic                step,
    output logic                phase_end,
    pixel_if.source             pix
);

    enum logic [1:0] {mode_idle, mode_clear, mode_draw} mode;

    logic [x_w-1:0]      scan_x, cx;
    logic [y_w-1:0]      scan_y, cy;
    logic [colour_w-1:0] pen_colour;  // colour of the circle being drawn

    logic clear_mode, draw_mode, xfer;
    logic scan_last_x, scan_last_y;

    // offsets and sums carry one extra bit so the centre can be added signed
    logic signed [offset_w:0] ox, oy, dx, dy;
    logic signed [offset_w:0] sum_x, sum_y;
    logic                     on_screen;

    assign clear_mode = (mode == mode_clear);
    assign draw_mode  = (mode == mode_draw);
    assign xfer       = pix.valid && pix.ready;

    assign scan_last_x = (scan_x == x_w'(screen_w - 1));
    assign scan_last_y = (scan_y == y_w'(screen_h - 1));

    assign ox = $signed({offset_x[offset_w-1], offset_x});
    assign oy = $signed({offset_y[offset_w-1], offset_y});

    // mirror the offset pair into the current octant
    always_comb begin
        case (octant)
            3'd0: begin dx =  ox; dy =  oy; end
            3'd1: begin dx =  oy; dy =  ox; end
            3'd2: begin dx = -ox; dy =  oy; end
            3'd3: begin dx = -oy; dy =  ox; end
            3'd4: begin dx = -ox; dy = -oy; end
            3'd5: begin dx = -oy; dy = -ox; end
            3'd6: begin dx =  ox; dy = -oy; end
            default: begin dx = oy; dy = -ox; end
        endcase
    end

    assign sum_x = $signed({{(offset_w + 1 - x_w){1'b0}}, cx}) + dx;
    assign sum_y = $signed({{(offset_w + 1 - y_w){1'b0}}, cy}) + dy;

    // negative sums show up in the top bit
    assign on_screen = !sum_x[offset_w] && (sum_x[offset_w-1:0] < offset_w'(screen_w))
                    && !sum_y[offset_w] && (sum_y[offset_w-1:0] < offset_w'(screen_h));

    assign pix.x      = draw_mode ? sum_x[x_w-1:0] : scan_x;
    assign pix.y      = draw_mode ? sum_y[y_w-1:0] : scan_y;
    assign pix.colour = draw_mode ? pen_colour : clear_colour;
    assign pix.valid  = clear_mode || (draw_mode && on_screen);

    // clipped pixels cost one cycle and are never shown
    assign step = draw_mode && (xfer || !on_screen);

    assign phase_end = (clear_mode && xfer && scan_last_x && scan_last_y)
                    || (step && last);

    always_ff @(posedge clk) begin
        if (reset) begin
            mode   <= mode_idle;
            scan_x <= '0;
            scan_y <= '0;
        end else if (clear_go) begin
            mode   <= mode_clear;
            scan_x <= '0;
            scan_y <= '0;
        end else if (draw_go) begin
            mode <= mode_draw;
        end else if (phase_end) begin
            mode <= mode_idle;
        end else if (clear_mode && xfer) begin
            // x runs fastest, then y
            if (scan_last_x) begin
                scan_x <= '0;
                scan_y <= scan_y + 1'b1;
            end else begin
                scan_x <= scan_x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (draw_go) begin
            cx         <= centre_x;  // inputs may change once drawing runs
            cy         <= centre_y;
            pen_colour <= colour;
        end
    end

    // a stalled pixel keeps its position and colour until it is taken
    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        (pix.valid && !pix.ready) |=>
            (pix.valid && $stable(pix.x) && $stable(pix.y) && $stable(pix.colour))
    );

endmodule : plot_generator

`default_nettype wire

//--- logic/screen_pkg.sv
/*
 * screen_pkg
 *   geometry of the 160x120 display, coordinate widths,
 *   colour width, frame buffer address width and the clear colour
 */

`default_nettype none

package screen_pkg;

    // visible area in pixels
    localparam int screen_w = 160;
    localparam int screen_h = 120;

    localparam int x_w = 8;  // x runs 0..159
    localparam int y_w = 7;  // y runs 0..119

    // three bits, one each for red, green and blue
    localparam int colour_w = 3;

    // one word per pixel in the frame buffer
    localparam int addr_w = $clog2(screen_w * screen_h);

    // clearing paints the whole screen black
    localparam logic [colour_w-1:0] clear_colour = '0;

endpackage : screen_pkg

`default_nettype wire

//--- sim/circle_input.txt
# case  centre_x centre_y radius colour draw_transfers
# probe x y colour, read from the frame buffer after the case above it
case 80 60 10 5 64
probe 90 60 5
probe 80 70 5
probe 87 67 5
probe 89 64 5
probe 80 60 0
probe 85 62 0
case 0 0 5 3 10
probe 90 60 0
probe 5 0 3
probe 3 4 3
probe 1 1 0
case 159 119 5 7 10
probe 154 119 7
probe 159 114 7
probe 155 116 7
probe 157 117 0
case 10 10 0 6 8
probe 10 10 6
probe 11 10 0
case 40 40 1 4 16
probe 41 41 4
probe 40 40 0
case 3 60 5 2 24
probe 8 60 2
probe 0 56 2
probe 3 60 0
case 157 60 3 1 20
probe 158 63 1
probe 159 62 1
probe 157 60 0

//--- sim/circle_tb.sv
/*
 * circle_tb
 *   testbench for circle_top: reads circle cases and probe pixels from
 *   the input file, drives a random plot_ready and checks the plot
 *   stream, the transfer counts and the frame buffer contents
 */

`default_nettype none
`timescale 1ns/100ps

module circle_tb import screen_pkg::*, circle_pkg::*; ();

    localparam int clear_total = screen_w * screen_h;
    localparam int op_timeout  = 200000;  // cycles allowed for one clear and draw

    logic                clk;
    logic                reset;
    logic                start;
    logic [x_w-1:0]      centre_x;
    logic [y_w-1:0]      centre_y;
    logic [radius_w-1:0] radius;
    logic [colour_w-1:0] colour;
    logic                plot_ready;
    logic [x_w-1:0]      rd_x;
    logic [y_w-1:0]      rd_y;
    logic                done;
    logic [x_w-1:0]      vga_x;
    logic [y_w-1:0]      vga_y;
    logic [colour_w-1:0] vga_colour;
    logic                vga_plot;
    logic [colour_w-1:0] rd_colour;

    int          value_errors;
    int          protocol_errors;
    int          run_errors;
    int          op_xfers;   // transfers since the last start
    logic [31:0] lcg_state;

    // pixel that was stalled at the previous falling edge
    logic                held;
    logic [x_w-1:0]      held_x;
    logic [y_w-1:0]      held_y;
    logic [colour_w-1:0] held_colour;

    circle_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // the display is ready about three cycles out of four
    always @(posedge clk) begin
        #1;
        lcg_state  = lcg_next(lcg_state);
        plot_ready = (lcg_state[17:16] != 2'b00);
    end

    task automatic check_colour(input string name, input logic [colour_w-1:0] expected,
                                input logic [colour_w-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // the stream is sampled mid cycle, where every output has settled
    always @(negedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            if (held && !(vga_plot === 1'b1 && vga_x == held_x && vga_y == held_y
                          && vga_colour == held_colour)) begin
                protocol_errors++;
                $display("ERROR: stalled pixel at x=%0d y=%0d changed before it transferred",
                         held_x, held_y);
            end
            if (vga_plot && (vga_x >= x_w'(screen_w) || vga_y >= y_w'(screen_h))) begin
                protocol_errors++;
                $display("ERROR: pixel presented off the screen at x=%0d y=%0d", vga_x, vga_y);
            end
            if (vga_plot && plot_ready) begin
                if (op_xfers < clear_total)
                    check_colour("clear pixel colour", colour_w'(0), vga_colour);
                op_xfers++;
            end
            held        = vga_plot && !plot_ready;
            held_x      = vga_x;
            held_y      = vga_y;
            held_colour = vga_colour;
        end
    end

    task automatic run_case(input int cx, input int cy, input int r, input int col,
                            input int expected, input int case_no, output logic timed_out);
        int cycles;
        centre_x = x_w'(cx);
        centre_y = y_w'(cy);
        radius   = radius_w'(r);
        colour   = colour_w'(col);
        op_xfers = 0;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 0;
        while (done !== 1'b1 && cycles < op_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        timed_out = (done !== 1'b1);
        if (timed_out) begin
            run_errors++;
            $display("ERROR: case %0d did not raise done within %0d cycles", case_no, op_timeout);
        end else begin
            check_count($sformatf("case %0d clear transfers", case_no), clear_total,
                        (op_xfers < clear_total) ? op_xfers : clear_total);
            check_count($sformatf("case %0d draw transfers", case_no), expected,
                        op_xfers - clear_total);
        end
    endtask

    // read port answers one cycle after the address
    task automatic probe_pixel(input int x, input int y, input int expected, input int case_no);
        rd_x = x_w'(x);
        rd_y = y_w'(y);
        @(posedge clk);
        #1;
        check_colour($sformatf("case %0d probe (%0d,%0d)", case_no, x, y),
                     colour_w'(expected), rd_colour);
    endtask

    initial begin
        int    fd;
        int    n;
        int    case_no;
        int    a, b, c, d, e;
        string line;
        string tag;
        logic  aborted;

        reset      = 1'b1;
        start      = 1'b0;
        centre_x   = '0;
        centre_y   = '0;
        radius     = '0;
        colour     = '0;
        plot_ready = 1'b0;
        rd_x       = '0;
        rd_y       = '0;
        lcg_state  = 32'd34848;
        held       = 1'b0;
        op_xfers   = 0;
        value_errors    = 0;
        protocol_errors = 0;
        run_errors      = 0;
        case_no = 0;
        aborted = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        if (done !== 1'b0 || vga_plot !== 1'b0) begin
            protocol_errors++;
            $display("ERROR: done or vga_plot is not low after reset");
        end

        fd = $fopen("sim/circle_input.txt", "r");
        if (fd == 0) begin
            run_errors++;
            $display("ERROR: cannot open sim/circle_input.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %d %d %d %d %d", tag, a, b, c, d, e);
            if (n == 6 && tag == "case") begin
                case_no++;
                run_case(a, b, c, d, e, case_no, aborted);
            end else if (n == 4 && tag == "probe") begin
                probe_pixel(a, b, c, case_no);
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("errors: %0d value, %0d protocol, %0d run",
                 value_errors, protocol_errors, run_errors);
        if (value_errors + protocol_errors + run_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule : circle_tb

`default_nettype wire
